/* dspPkg.sv */
package dspPkg;

	// **************************************************
	// Data widths

	parameter int codeWidth = 8; // Bits of one ADC code.
	parameter int weightWidth = 11; // Bits of one tap weight.
	parameter int resultWidth = 8; // Bits of one equalized estimate.
	parameter int shiftWidth = 5; // Bits of a per-channel shift amount.

	// **************************************************
	// Sample types

	typedef logic signed [codeWidth-1:0] codeT; // Signed ADC code.
	typedef logic signed [weightWidth-1:0] weightT; // Signed tap weight.
	typedef logic signed [resultWidth-1:0] resultT; // Signed estimate after shift.
	typedef logic [shiftWidth-1:0] shiftT; // Arithmetic right shift amount.

	// Per-channel slicer output.
	typedef struct packed {
		resultT estimate; // Truncated equalizer sum.
		logic decision; // High when the estimate is zero or positive.
	} estimateT;

endpackage

/* ctrlPkg.sv */
package ctrlPkg;

	// **************************************************
	// Configuration port

	typedef enum logic [1:0] {
		cfgWeight, // Write one tap weight of one channel.
		cfgDisable, // Write one tap disable of one channel.
		cfgShift // Write the shift amount of one channel.
	} cfgKindT;

	typedef struct packed {
		cfgKindT kind; // What the word writes.
		logic [3:0] tap; // Tap index, ignored by shift words.
		logic [3:0] channel; // Channel index.
		dspPkg::weightT value; // Weight, disable in bit 0 or shift in the low bits.
	} cfgWordT;

	// **************************************************
	// Handshake states

	typedef enum logic {hsIdle, hsAck} hsStateT; // Four-phase receiver.

	typedef enum logic [1:0] {sendIdle, sendReq, sendRelease} sendStateT; // Four-phase sender.

endpackage

/* codeBuffer.sv */
`timescale 1ns/1ps

module codeBuffer #(
	parameter int numChannels = 16
) (
	input logic clk,
	input logic arstN,
	input logic inReq,
	output logic inAck,
	input dspPkg::codeT [numChannels-1:0] inFrame,
	input logic busy,
	output logic histValid,
	output dspPkg::codeT [2*numChannels-1:0] history
);

	ctrlPkg::hsStateT state;
	dspPkg::codeT [numChannels-1:0] frameReg; // Frame taken from the input port.
	logic frameValid;
	logic accept;
	logic histLoad;

	assign accept = (state == ctrlPkg::hsIdle) && inReq && !frameValid; // Slot free and request up.
	assign histLoad = frameValid && (!histValid || !busy); // History empty or being taken.
	assign inAck = (state == ctrlPkg::hsAck);

	// **************************************************
	// Input four-phase receiver

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= ctrlPkg::hsIdle;
		end else begin
			case (state)
				ctrlPkg::hsIdle: if (accept) state <= ctrlPkg::hsAck;
				ctrlPkg::hsAck: if (!inReq) state <= ctrlPkg::hsIdle; // Source released the request.
				default: state <= ctrlPkg::hsIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) frameReg <= inFrame;
	end

	// **************************************************
	// Two-frame code history, oldest code at index 0

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			frameValid <= 1'b0;
			histValid <= 1'b0;
			history <= '0;
		end else begin
			if (accept) frameValid <= 1'b1;
			else if (histLoad) frameValid <= 1'b0;
			if (histLoad) begin
				history[numChannels-1:0] <= history[2*numChannels-1:numChannels]; // Current becomes previous.
				history[2*numChannels-1:numChannels] <= frameReg; // Newest frame at the cursor.
				histValid <= 1'b1;
			end else if (!busy) begin
				histValid <= 1'b0; // Taken by the compute stage.
			end
		end
	end

endmodule

/* weightBank.sv */
`timescale 1ns/1ps

module weightBank #(
	parameter int numChannels = 16,
	parameter int ffeDepth = 5
) (
	input logic clk,
	input logic arstN,
	input logic cfgReq,
	output logic cfgAck,
	input ctrlPkg::cfgWordT cfgWord,
	output dspPkg::weightT [ffeDepth-1:0][numChannels-1:0] weights,
	output logic [ffeDepth-1:0][numChannels-1:0] disables,
	output dspPkg::shiftT [numChannels-1:0] shifts
);

	ctrlPkg::hsStateT state;
	logic apply;

	assign apply = (state == ctrlPkg::hsIdle) && cfgReq; // Word applied as the ack rises.
	assign cfgAck = (state == ctrlPkg::hsAck);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= ctrlPkg::hsIdle;
		end else begin
			case (state)
				ctrlPkg::hsIdle: if (apply) state <= ctrlPkg::hsAck;
				ctrlPkg::hsAck: if (!cfgReq) state <= ctrlPkg::hsIdle;
				default: state <= ctrlPkg::hsIdle;
			endcase
		end
	end

	// **************************************************
	// Register writes, an address out of range matches nothing

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			weights <= '0;
			disables <= '0;
			shifts <= '0;
		end else if (apply) begin
			for (int t = 0; t < ffeDepth; t++) begin
				for (int c = 0; c < numChannels; c++) begin
					if (int'(cfgWord.tap) == t && int'(cfgWord.channel) == c) begin
						case (cfgWord.kind)
							ctrlPkg::cfgWeight: weights[t][c] <= cfgWord.value;
							ctrlPkg::cfgDisable: disables[t][c] <= cfgWord.value[0];
							default: ; // Shift words are handled per channel below.
						endcase
					end
				end
			end
			for (int c = 0; c < numChannels; c++) begin
				if (cfgWord.kind == ctrlPkg::cfgShift && int'(cfgWord.channel) == c) begin
					shifts[c] <= dspPkg::shiftT'(cfgWord.value[dspPkg::shiftWidth-1:0]);
				end
			end
		end
	end

endmodule

/* ffeCompute.sv */
`timescale 1ns/1ps

module ffeCompute #(
	parameter int numChannels = 16,
	parameter int ffeDepth = 5
) (
	input logic clk,
	input logic arstN,
	input logic histValid,
	input dspPkg::codeT [2*numChannels-1:0] history,
	output logic busy,
	input dspPkg::weightT [ffeDepth-1:0][numChannels-1:0] weights,
	input logic [ffeDepth-1:0][numChannels-1:0] disables,
	input dspPkg::shiftT [numChannels-1:0] shifts,
	output logic estValid,
	output dspPkg::resultT [numChannels-1:0] estimates,
	input logic downBusy
);

	localparam int productWidth = dspPkg::codeWidth + dspPkg::weightWidth;
	localparam int sumWidth = $clog2(ffeDepth) + productWidth; // Room for every tap without overflow.

	typedef logic signed [sumWidth-1:0] sumT;

	dspPkg::codeT [ffeDepth-1:0][numChannels-1:0] tapCodes;
	dspPkg::weightT [ffeDepth-1:0][numChannels-1:0] tapWeights;
	sumT [numChannels-1:0] sums;
	sumT [numChannels-1:0] shiftedSums;
	logic load;

	// **************************************************
	// Tap selection

	always_comb begin
		for (int k = 0; k < ffeDepth; k++) begin
			for (int c = 0; c < numChannels; c++) begin
				// Tap k reaches k codes back and may land in the previous frame.
				tapCodes[k][c] = disables[k][c] ? '0 : history[numChannels + c - k];
				tapWeights[k][c] = disables[k][c] ? '0 : weights[k][c];
			end
		end
	end

	// **************************************************
	// Accumulation, shift and truncation

	always_comb begin
		for (int c = 0; c < numChannels; c++) begin
			sums[c] = '0;
			for (int k = 0; k < ffeDepth; k++) begin
				sums[c] = sums[c] + sumT'(tapCodes[k][c]) * sumT'(tapWeights[k][c]);
			end
			shiftedSums[c] = sums[c] >>> shifts[c]; // Sign is kept by the arithmetic shift.
		end
	end

	// **************************************************
	// Output register

	assign busy = estValid && downBusy; // Full and the slicer cannot take it.
	assign load = histValid && !busy;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			estValid <= 1'b0;
		end else if (load) begin
			estValid <= 1'b1;
		end else if (!downBusy) begin
			estValid <= 1'b0; // Slicer took the estimates.
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			for (int c = 0; c < numChannels; c++) begin
				estimates[c] <= dspPkg::resultT'(shiftedSums[c][dspPkg::resultWidth-1:0]);
			end
		end
	end

endmodule

/* bitSlicer.sv */
`timescale 1ns/1ps

module bitSlicer #(
	parameter int numChannels = 16
) (
	input logic clk,
	input logic arstN,
	input logic estValid,
	input dspPkg::resultT [numChannels-1:0] estimates,
	output logic busy,
	output logic outReq,
	input logic outAck,
	output dspPkg::estimateT [numChannels-1:0] outFrame
);

	ctrlPkg::sendStateT state;
	logic releaseDone;
	logic load;

	assign releaseDone = (state == ctrlPkg::sendRelease) && !outAck; // Sink finished the exchange.
	assign busy = (state != ctrlPkg::sendIdle) && !releaseDone;
	assign load = estValid && !busy;
	assign outReq = (state == ctrlPkg::sendReq);

	// **************************************************
	// Output four-phase sender

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= ctrlPkg::sendIdle;
		end else begin
			case (state)
				ctrlPkg::sendIdle: if (load) state <= ctrlPkg::sendReq;
				ctrlPkg::sendReq: if (outAck) state <= ctrlPkg::sendRelease;
				ctrlPkg::sendRelease: begin
					if (!outAck) state <= load ? ctrlPkg::sendReq : ctrlPkg::sendIdle;
				end
				default: state <= ctrlPkg::sendIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			for (int c = 0; c < numChannels; c++) begin
				outFrame[c].estimate <= estimates[c];
				outFrame[c].decision <= !estimates[c][dspPkg::resultWidth-1]; // Zero counts as one.
			end
		end
	end

endmodule

/* ffeTop.sv */
`timescale 1ns/1ps

module ffeTop #(
	parameter int numChannels = 16,
	parameter int ffeDepth = 5 // At most numChannels + 1.
) (
	input logic clk,
	input logic arstN,
	input logic inReq,
	output logic inAck,
	input dspPkg::codeT [numChannels-1:0] inFrame,
	input logic cfgReq,
	output logic cfgAck,
	input ctrlPkg::cfgWordT cfgWord,
	output logic outReq,
	input logic outAck,
	output dspPkg::estimateT [numChannels-1:0] outFrame
);

	logic histValid;
	dspPkg::codeT [2*numChannels-1:0] history;
	logic computeBusy; // Compute stage cannot take new history.
	dspPkg::weightT [ffeDepth-1:0][numChannels-1:0] weights;
	logic [ffeDepth-1:0][numChannels-1:0] disables;
	dspPkg::shiftT [numChannels-1:0] shifts;
	logic estValid;
	dspPkg::resultT [numChannels-1:0] estimates;
	logic slicerBusy; // Slicer is still sending a frame.

	codeBuffer #(.numChannels(numChannels)) codeBuffer_i (
		.clk(clk), .arstN(arstN),
		.inReq(inReq), .inAck(inAck), .inFrame(inFrame),
		.busy(computeBusy), .histValid(histValid), .history(history)
	);

	weightBank #(.numChannels(numChannels), .ffeDepth(ffeDepth)) weightBank_i (
		.clk(clk), .arstN(arstN),
		.cfgReq(cfgReq), .cfgAck(cfgAck), .cfgWord(cfgWord),
		.weights(weights), .disables(disables), .shifts(shifts)
	);

	ffeCompute #(.numChannels(numChannels), .ffeDepth(ffeDepth)) ffeCompute_i (
		.clk(clk), .arstN(arstN),
		.histValid(histValid), .history(history), .busy(computeBusy),
		.weights(weights), .disables(disables), .shifts(shifts),
		.estValid(estValid), .estimates(estimates), .downBusy(slicerBusy)
	);

	bitSlicer #(.numChannels(numChannels)) bitSlicer_i (
		.clk(clk), .arstN(arstN),
		.estValid(estValid), .estimates(estimates), .busy(slicerBusy),
		.outReq(outReq), .outAck(outAck), .outFrame(outFrame)
	);

endmodule

/* ffeTb.sv */
`timescale 1ns/1ps

module ffeTb;

	localparam int numChannels = 16;
	localparam int ffeDepth = 5;
	localparam int clkPeriod = 4; // Nanoseconds.
	localparam int frameTotal = 81; // Frames sent over all tests.
	localparam int cfgTotal = 128; // Configuration words sent over all tests.

	typedef dspPkg::codeT [numChannels-1:0] inFrameT;
	typedef dspPkg::estimateT [numChannels-1:0] outFrameT;

	logic clk;
	logic arstN;
	logic inReq;
	logic inAck;
	inFrameT inFrame;
	logic cfgReq;
	logic cfgAck;
	ctrlPkg::cfgWordT cfgWord;
	logic outReq;
	logic outAck;
	outFrameT outFrame;

	dspPkg::weightT mWeight[ffeDepth][numChannels]; // Mirror of the weight bank.
	logic mDisable[ffeDepth][numChannels];
	dspPkg::shiftT mShift[numChannels];
	inFrameT prevFrame; // Older half of the DUT history.
	outFrameT expQ[$]; // Expected output frames in send order.
	string testName;
	int ackDelayMax; // Longest sink delay before outAck rises.

	ffeTop #(.numChannels(numChannels), .ffeDepth(ffeDepth)) ffeTop_i (
		.clk(clk), .arstN(arstN),
		.inReq(inReq), .inAck(inAck), .inFrame(inFrame),
		.cfgReq(cfgReq), .cfgAck(cfgAck), .cfgWord(cfgWord),
		.outReq(outReq), .outAck(outAck), .outFrame(outFrame)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic abortRun(input string why);
		$display("Failure: %s.", why);
		$display("tests failed");
		$fatal(1, "Simulation stopped.");
	endtask

	task automatic reportMismatch(input string name, input int channel,
			input dspPkg::estimateT expected, input dspPkg::estimateT actual);
		$display("[ERROR] %s channel %0d: expected %0d/%0b, actual %0d/%0b", name, channel,
			expected.estimate, expected.decision, actual.estimate, actual.decision);
		$display("tests failed");
		$fatal(1, "Simulation stopped.");
	endtask

	// **************************************************
	// Reference model

	function automatic outFrameT expectFrame(input inFrameT frame);
		outFrameT res;
		int idx;
		longint sum;
		dspPkg::codeT code;
		dspPkg::resultT est;
		for (int c = 0; c < numChannels; c++) begin
			sum = 0;
			for (int k = 0; k < ffeDepth; k++) begin
				idx = numChannels + c - k; // Below numChannels the code is in the previous frame.
				code = (idx >= numChannels) ? frame[idx - numChannels] : prevFrame[idx];
				if (!mDisable[k][c]) sum += longint'(code) * longint'(mWeight[k][c]);
			end
			est = dspPkg::resultT'(sum >>> mShift[c]); // Keep the low result bits.
			res[c].estimate = est;
			res[c].decision = (est >= 0);
		end
		return res;
	endfunction

	function automatic inFrameT randomFrame();
		inFrameT f;
		for (int c = 0; c < numChannels; c++) f[c] = dspPkg::codeT'($urandom);
		return f;
	endfunction

	// **************************************************
	// Port drivers

	task automatic sendCfg(input ctrlPkg::cfgKindT kind, input int tap, input int channel,
			input int value);
		ctrlPkg::cfgWordT word;
		word.kind = kind;
		word.tap = 4'(tap);
		word.channel = 4'(channel);
		word.value = dspPkg::weightT'(value);
		case (kind)
			ctrlPkg::cfgWeight: mWeight[tap][channel] = word.value;
			ctrlPkg::cfgDisable: mDisable[tap][channel] = word.value[0];
			default: mShift[channel] = dspPkg::shiftT'(value);
		endcase
		@(posedge clk);
		cfgWord <= word;
		cfgReq <= 1'b1;
		do @(negedge clk); while (!cfgAck);
		@(posedge clk);
		cfgReq <= 1'b0;
		do @(negedge clk); while (cfgAck);
	endtask

	task automatic sendFrame(input inFrameT frame);
		expQ.push_back(expectFrame(frame));
		prevFrame = frame;
		@(posedge clk);
		inFrame <= frame;
		inReq <= 1'b1;
		do @(negedge clk); while (!inAck);
		@(posedge clk);
		inReq <= 1'b0;
		do @(negedge clk); while (inAck);
	endtask

	task automatic runFrames(input string name, input int count, input int gapMax);
		testName = name;
		for (int i = 0; i < count; i++) begin
			repeat ($urandom_range(0, gapMax)) @(posedge clk);
			sendFrame(randomFrame());
		end
		while (expQ.size() != 0) @(posedge clk); // Drained before the weights change.
	endtask

	initial begin : outputSink
		outFrameT expected;
		@(posedge arstN);
		forever begin
			do @(negedge clk); while (!outReq);
			assert (expQ.size() != 0) else abortRun("an output frame arrived that was never sent");
			expected = expQ.pop_front();
			for (int c = 0; c < numChannels; c++) begin
				assert (outFrame[c] == expected[c])
					else reportMismatch(testName, c, expected[c], outFrame[c]);
			end
			repeat ($urandom_range(0, ackDelayMax)) @(posedge clk);
			@(posedge clk);
			outAck <= 1'b1;
			do @(negedge clk); while (outReq);
			@(posedge clk);
			outAck <= 1'b0;
		end
	end

	// **************************************************
	// Port protocol checks

	assert property (@(posedge clk) disable iff (!arstN) inReq && !inAck |=> inReq)
		else abortRun("inReq fell before inAck rose");
	assert property (@(posedge clk) disable iff (!arstN) !inReq && inAck |=> !inReq)
		else abortRun("inReq rose before inAck fell");
	assert property (@(posedge clk) disable iff (!arstN) inReq |=> !inReq || $stable(inFrame))
		else abortRun("inFrame changed while inReq was high");
	assert property (@(posedge clk) disable iff (!arstN) inReq && inAck |=> inAck)
		else abortRun("inAck fell while inReq was still high");
	assert property (@(posedge clk) disable iff (!arstN) !inReq && !inAck |=> !inAck)
		else abortRun("inAck rose without a request");
	assert property (@(posedge clk) disable iff (!arstN) cfgReq && !cfgAck |=> cfgReq)
		else abortRun("cfgReq fell before cfgAck rose");
	assert property (@(posedge clk) disable iff (!arstN) !cfgReq && cfgAck |=> !cfgReq)
		else abortRun("cfgReq rose before cfgAck fell");
	assert property (@(posedge clk) disable iff (!arstN) cfgReq |=> !cfgReq || $stable(cfgWord))
		else abortRun("cfgWord changed while cfgReq was high");
	assert property (@(posedge clk) disable iff (!arstN) cfgReq && cfgAck |=> cfgAck)
		else abortRun("cfgAck fell while cfgReq was still high");
	assert property (@(posedge clk) disable iff (!arstN) !cfgReq && !cfgAck |=> !cfgAck)
		else abortRun("cfgAck rose without a request");
	assert property (@(posedge clk) disable iff (!arstN) outReq && !outAck |=> outReq)
		else abortRun("outReq fell before outAck rose");
	assert property (@(posedge clk) disable iff (!arstN) !outReq && outAck |=> !outReq)
		else abortRun("outReq rose while outAck was still high");
	assert property (@(posedge clk) disable iff (!arstN) outReq |=> !outReq || $stable(outFrame))
		else abortRun("outFrame changed while outReq was high");

	initial begin : watchdog
		#((frameTotal * 40 + cfgTotal * 10 + 50) * clkPeriod);
		abortRun("the run timed out before all frames came back");
	end

	initial begin : mainFlow
		void'($urandom(17532));
		arstN = 1'b0;
		inReq = 1'b0;
		inFrame = '0;
		cfgReq = 1'b0;
		cfgWord = '0;
		outAck = 1'b0;
		mWeight = '{default: '0};
		mDisable = '{default: 1'b0};
		mShift = '{default: '0};
		prevFrame = '0;
		ackDelayMax = 2;
		repeat (5) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		assert (!inAck && !cfgAck && !outReq)
			else abortRun("a handshake output is high after reset");
		runFrames("zeroWeights", 1, 0);
		for (int k = 0; k < ffeDepth; k++) begin
			for (int c = 0; c < numChannels; c++) begin
				sendCfg(ctrlPkg::cfgWeight, k, c, $urandom_range(0, 2047));
			end
		end
		runFrames("randomWeights", 30, 3);
		for (int c = 0; c < numChannels; c++) begin
			sendCfg(ctrlPkg::cfgDisable, 1, c, 1);
			sendCfg(ctrlPkg::cfgDisable, 4, c, c % 2); // Tap 4 is off on odd channels only.
			sendCfg(ctrlPkg::cfgShift, 0, c, $urandom_range(0, 20));
		end
		runFrames("disableShift", 20, 3);
		ackDelayMax = 10; // Slow sink fills the pipeline.
		runFrames("backPressure", 30, 0);
		repeat (20) @(posedge clk);
		assert (!outReq) else abortRun("an output frame was still pending at the end");
		$display("all tests passed");
		$finish;
	end

endmodule

/* verilog.f */
dspPkg.sv
ctrlPkg.sv
codeBuffer.sv
weightBank.sv
ffeCompute.sv
bitSlicer.sv
ffeTop.sv
ffeTb.sv

/* Makefile */
TOOL = verilator
FLAGS = --binary --timing --assert
TOP = ffeTb
FILELIST = verilog.f
BUILD = obj_dir
LOG = sim.log
PASS = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS)$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
